// ==== design/hk_gpio_pkg.sv ====
/* widths, register map, encodings and reset values of the housekeeping GPIO block
   the slave decodes a single 256-byte page; offsets are byte addresses */
package hk_gpio_pkg;

  localparam int gpio_w = 16;

  typedef logic [gpio_w-1:0] gpio_t;
  typedef logic [31:0]       bus_word_t;
  typedef logic [31:0]       bus_addr_t;
  typedef logic [3:0]        bus_strb_t;
  // zero means not routed, 1 to 3 pick a pin
  typedef logic [1:0]        route_sel_t;

  typedef enum logic [1:0] {
    bank_data,
    bank_oeb,
    bank_pu,
    bank_pd
  } pad_bank_e;

  typedef enum logic [2:0] {
    field_xtal,
    field_pll,
    field_trap,
    field_irq7,
    field_irq8
  } route_field_e;

  localparam logic [23:0] gpio_page = 24'h0300_00;

  localparam logic [7:0] ofs_data     = 8'h00;
  localparam logic [7:0] ofs_oeb      = 8'h04;
  localparam logic [7:0] ofs_pu       = 8'h08;
  localparam logic [7:0] ofs_pd       = 8'h0c;
  localparam logic [7:0] ofs_mfgr_id  = 8'h24;
  localparam logic [7:0] ofs_prod_id  = 8'h28;
  localparam logic [7:0] ofs_mask_rev = 8'h2c;
  localparam logic [7:0] ofs_clk_ext  = 8'h30;
  localparam logic [7:0] ofs_xtal     = 8'h34;
  localparam logic [7:0] ofs_pll      = 8'h38;
  localparam logic [7:0] ofs_trap     = 8'h3c;
  localparam logic [7:0] ofs_irq7     = 8'h40;
  localparam logic [7:0] ofs_irq8     = 8'h44;

  // outputs come up disabled
  localparam gpio_t oeb_reset = 16'hffff;

  // routed pin is base + select
  localparam int xtal_pin_base = 4;
  localparam int trap_pin_base = 10;
  localparam int pll_pin       = 8;
  localparam int core_clk_pin  = 9;

  // pins taken over while a select is nonzero
  localparam gpio_t xtal_grp_mask = 16'h00e0;
  localparam gpio_t pll_grp_mask  = 16'h0700;
  localparam gpio_t trap_grp_mask = 16'h3800;

  // irq source is gpio_in[base + select - 1]
  localparam int irq7_src_base = 0;
  localparam int irq8_src_base = 3;

endpackage

// ==== design/hk_bus_slave.sv ====
/* valid/ready slave with a fixed single-cycle response
   off-page and unmapped accesses are acknowledged, read as zero and write nothing */
`timescale 1ns/1ps

module hk_bus_slave (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      bus_valid_i,
  input  hk_gpio_pkg::bus_addr_t    bus_addr_i,
  input  hk_gpio_pkg::bus_strb_t    bus_wstrb_i,
  output logic                      bus_ready_o,
  output hk_gpio_pkg::bus_word_t    bus_rdata_o,
  output logic                      pad_wr_o,
  output hk_gpio_pkg::pad_bank_e    pad_bank_o,
  output logic                      route_wr_o,
  output hk_gpio_pkg::route_field_e route_field_o,
  input  hk_gpio_pkg::gpio_t        gpio_out_i,
  input  hk_gpio_pkg::gpio_t        gpio_in_i,
  input  hk_gpio_pkg::gpio_t        oeb_i,
  input  hk_gpio_pkg::gpio_t        pu_i,
  input  hk_gpio_pkg::gpio_t        pd_i,
  input  hk_gpio_pkg::route_sel_t   xtal_dest_i,
  input  hk_gpio_pkg::route_sel_t   pll_dest_i,
  input  hk_gpio_pkg::route_sel_t   trap_dest_i,
  input  hk_gpio_pkg::route_sel_t   irq7_src_i,
  input  hk_gpio_pkg::route_sel_t   irq8_src_i,
  input  logic [11:0]               mfgr_id_i,
  input  logic [7:0]                prod_id_i,
  input  logic [3:0]                mask_rev_i,
  input  logic                      clk_ext_sel_i
);

  logic                   access;
  logic                   pad_hit;
  logic                   route_hit;
  hk_gpio_pkg::bus_word_t rdata_next;

  // decoded once, in the cycle before ready
  assign access = bus_valid_i && !bus_ready_o;

  always_comb begin
    pad_hit       = 1'b0;
    route_hit     = 1'b0;
    pad_bank_o    = hk_gpio_pkg::bank_data;
    route_field_o = hk_gpio_pkg::field_xtal;
    rdata_next    = '0;
    if (bus_addr_i[31:8] == hk_gpio_pkg::gpio_page) begin
      case (bus_addr_i[7:0])
        hk_gpio_pkg::ofs_data: begin
          pad_hit    = 1'b1;
          // real pin values, not just the register
          rdata_next = {gpio_out_i, gpio_in_i};
        end
        hk_gpio_pkg::ofs_oeb: begin
          pad_hit    = 1'b1;
          pad_bank_o = hk_gpio_pkg::bank_oeb;
          rdata_next = hk_gpio_pkg::bus_word_t'(oeb_i);
        end
        hk_gpio_pkg::ofs_pu: begin
          pad_hit    = 1'b1;
          pad_bank_o = hk_gpio_pkg::bank_pu;
          rdata_next = hk_gpio_pkg::bus_word_t'(pu_i);
        end
        hk_gpio_pkg::ofs_pd: begin
          pad_hit    = 1'b1;
          pad_bank_o = hk_gpio_pkg::bank_pd;
          rdata_next = hk_gpio_pkg::bus_word_t'(pd_i);
        end
        hk_gpio_pkg::ofs_mfgr_id:  rdata_next = hk_gpio_pkg::bus_word_t'(mfgr_id_i);
        hk_gpio_pkg::ofs_prod_id:  rdata_next = hk_gpio_pkg::bus_word_t'(prod_id_i);
        hk_gpio_pkg::ofs_mask_rev: rdata_next = hk_gpio_pkg::bus_word_t'(mask_rev_i);
        hk_gpio_pkg::ofs_clk_ext:  rdata_next = hk_gpio_pkg::bus_word_t'(clk_ext_sel_i);
        hk_gpio_pkg::ofs_xtal: begin
          route_hit  = 1'b1;
          rdata_next = hk_gpio_pkg::bus_word_t'(xtal_dest_i);
        end
        hk_gpio_pkg::ofs_pll: begin
          route_hit     = 1'b1;
          route_field_o = hk_gpio_pkg::field_pll;
          rdata_next    = hk_gpio_pkg::bus_word_t'(pll_dest_i);
        end
        hk_gpio_pkg::ofs_trap: begin
          route_hit     = 1'b1;
          route_field_o = hk_gpio_pkg::field_trap;
          rdata_next    = hk_gpio_pkg::bus_word_t'(trap_dest_i);
        end
        hk_gpio_pkg::ofs_irq7: begin
          route_hit     = 1'b1;
          route_field_o = hk_gpio_pkg::field_irq7;
          rdata_next    = hk_gpio_pkg::bus_word_t'(irq7_src_i);
        end
        hk_gpio_pkg::ofs_irq8: begin
          route_hit     = 1'b1;
          route_field_o = hk_gpio_pkg::field_irq8;
          rdata_next    = hk_gpio_pkg::bus_word_t'(irq8_src_i);
        end
        default: ;
      endcase
    end
  end

  // any nonzero strobe makes it a write
  assign pad_wr_o   = access && pad_hit && (bus_wstrb_i != '0);
  assign route_wr_o = access && route_hit && (bus_wstrb_i != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bus_ready_o <= 1'b0;
    end else begin
      bus_ready_o <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      bus_rdata_o <= rdata_next;
    end
  end

  // master must see a low ready before its next request is taken
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_ready_o |=> !bus_ready_o);

  a_wr_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pad_wr_o || route_wr_o) |-> bus_valid_i);

endmodule

// ==== design/gpio_pad_regs.sv ====
/* data, oeb, pull-up and pull-down pad registers
   only strobe bits 0 and 1 matter, upper half of the bus word is ignored */
`timescale 1ns/1ps

module gpio_pad_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   pad_wr_i,
  input  hk_gpio_pkg::pad_bank_e pad_bank_i,
  input  hk_gpio_pkg::bus_word_t wdata_i,
  input  hk_gpio_pkg::bus_strb_t wstrb_i,
  output hk_gpio_pkg::gpio_t     gpio_o,
  output hk_gpio_pkg::gpio_t     oeb_o,
  output hk_gpio_pkg::gpio_t     pu_o,
  output hk_gpio_pkg::gpio_t     pd_o
);

  // byte-lane merge of a write into a 16-bit register
  function automatic hk_gpio_pkg::gpio_t merge_bytes(
    input hk_gpio_pkg::gpio_t     cur,
    input hk_gpio_pkg::bus_word_t wdata,
    input hk_gpio_pkg::bus_strb_t wstrb
  );
    hk_gpio_pkg::gpio_t res;
    res = cur;
    if (wstrb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (wstrb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o <= '0;
      oeb_o  <= hk_gpio_pkg::oeb_reset;
      pu_o   <= '0;
      pd_o   <= '0;
    end else if (pad_wr_i) begin
      case (pad_bank_i)
        hk_gpio_pkg::bank_data: gpio_o <= merge_bytes(gpio_o, wdata_i, wstrb_i);
        hk_gpio_pkg::bank_oeb:  oeb_o  <= merge_bytes(oeb_o, wdata_i, wstrb_i);
        hk_gpio_pkg::bank_pu:   pu_o   <= merge_bytes(pu_o, wdata_i, wstrb_i);
        hk_gpio_pkg::bank_pd:   pd_o   <= merge_bytes(pd_o, wdata_i, wstrb_i);
        default: ;
      endcase
    end
  end

endmodule

// ==== design/pin_route_regs.sv ====
/* routing and interrupt-source selects, written from data bits 1:0 under strobe bit 0
   interrupt outputs are combinational from gpio_in_i */
`timescale 1ns/1ps

module pin_route_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      route_wr_i,
  input  hk_gpio_pkg::route_field_e route_field_i,
  input  hk_gpio_pkg::bus_word_t    wdata_i,
  input  hk_gpio_pkg::bus_strb_t    wstrb_i,
  input  hk_gpio_pkg::gpio_t        gpio_in_i,
  output hk_gpio_pkg::route_sel_t   xtal_dest_o,
  output hk_gpio_pkg::route_sel_t   pll_dest_o,
  output hk_gpio_pkg::route_sel_t   trap_dest_o,
  output hk_gpio_pkg::route_sel_t   irq7_src_o,
  output hk_gpio_pkg::route_sel_t   irq8_src_o,
  output logic                      irq7_o,
  output logic                      irq8_o
);

  hk_gpio_pkg::route_sel_t wsel;

  // select 0 gives a quiet interrupt
  function automatic logic pick_irq(
    input hk_gpio_pkg::route_sel_t src,
    input hk_gpio_pkg::gpio_t      pins,
    input int                      base
  );
    logic irq;
    irq = 1'b0;
    if (src != '0) begin
      irq = pins[base + int'(src) - 1];
    end
    return irq;
  endfunction

  assign wsel = wdata_i[1:0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      xtal_dest_o <= '0;
      pll_dest_o  <= '0;
      trap_dest_o <= '0;
      irq7_src_o  <= '0;
      irq8_src_o  <= '0;
    end else if (route_wr_i && wstrb_i[0]) begin
      case (route_field_i)
        hk_gpio_pkg::field_xtal: xtal_dest_o <= wsel;
        hk_gpio_pkg::field_pll:  pll_dest_o  <= wsel;
        hk_gpio_pkg::field_trap: trap_dest_o <= wsel;
        hk_gpio_pkg::field_irq7: irq7_src_o  <= wsel;
        hk_gpio_pkg::field_irq8: irq8_src_o  <= wsel;
        default: ;
      endcase
    end
  end

  assign irq7_o = pick_irq(irq7_src_o, gpio_in_i, hk_gpio_pkg::irq7_src_base);
  assign irq8_o = pick_irq(irq8_src_o, gpio_in_i, hk_gpio_pkg::irq8_src_base);

  // pin mux indexes with these, an X would scatter onto several pins
  a_sel_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown({xtal_dest_o, pll_dest_o, trap_dest_o, irq7_src_o, irq8_src_o}));

endmodule

// ==== design/gpio_pad_mux.sv ====
/* merges pad registers and routing selects into the pad outputs
   routed pins are forced to output with both pulls off; oeb is all ones in reset */
`timescale 1ns/1ps

module gpio_pad_mux (
  input  logic                    rst_n_i,
  input  logic                    xtal_in_i,
  input  logic                    clk_pll_i,
  input  logic                    clk_i,
  input  logic                    trap_i,
  input  hk_gpio_pkg::gpio_t      gpio_i,
  input  hk_gpio_pkg::gpio_t      oeb_i,
  input  hk_gpio_pkg::gpio_t      pu_i,
  input  hk_gpio_pkg::gpio_t      pd_i,
  input  hk_gpio_pkg::route_sel_t xtal_dest_i,
  input  hk_gpio_pkg::route_sel_t pll_dest_i,
  input  hk_gpio_pkg::route_sel_t trap_dest_i,
  output hk_gpio_pkg::gpio_t      gpio_out_o,
  output hk_gpio_pkg::gpio_t      gpio_outenb_o,
  output hk_gpio_pkg::gpio_t      gpio_pullupb_o,
  output hk_gpio_pkg::gpio_t      gpio_pulldownb_o
);

  hk_gpio_pkg::gpio_t grp;

  // pins owned by an active route
  always_comb begin
    grp = '0;
    if (xtal_dest_i != '0) begin
      grp = grp | hk_gpio_pkg::xtal_grp_mask;
    end
    if (pll_dest_i != '0) begin
      grp = grp | hk_gpio_pkg::pll_grp_mask;
    end
    if (trap_dest_i != '0) begin
      grp = grp | hk_gpio_pkg::trap_grp_mask;
    end
  end

  always_comb begin
    gpio_out_o = gpio_i;
    if (xtal_dest_i != '0) begin
      gpio_out_o[hk_gpio_pkg::xtal_pin_base + int'(xtal_dest_i)] = xtal_in_i;
    end
    // select 3 leaves pins 8 to 10 on the data register
    case (pll_dest_i)
      2'd1: gpio_out_o[hk_gpio_pkg::pll_pin] = clk_pll_i;
      2'd2: gpio_out_o[hk_gpio_pkg::core_clk_pin] = clk_i;
      default: ;
    endcase
    if (trap_dest_i != '0) begin
      gpio_out_o[hk_gpio_pkg::trap_pin_base + int'(trap_dest_i)] = trap_i;
    end
  end

  assign gpio_outenb_o    = rst_n_i ? (oeb_i & ~grp) : '1;
  assign gpio_pullupb_o   = pu_i | grp;
  assign gpio_pulldownb_o = pd_i | grp;

  // pads stay tristate through reset whatever the register holds
  a_oeb_in_reset: assert property (@(posedge clk_i)
    !rst_n_i |-> (gpio_outenb_o == '1));

endmodule

// ==== design/hk_gpio_top.sv ====
/* housekeeping GPIO slave with pin routing
   one request per two cycles at most; pin outputs are combinational */
`timescale 1ns/1ps

module hk_gpio_top (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   bus_valid_i,
  input  hk_gpio_pkg::bus_addr_t bus_addr_i,
  input  hk_gpio_pkg::bus_word_t bus_wdata_i,
  input  hk_gpio_pkg::bus_strb_t bus_wstrb_i,
  output logic                   bus_ready_o,
  output hk_gpio_pkg::bus_word_t bus_rdata_o,
  input  logic                   xtal_in_i,
  input  logic                   clk_pll_i,
  input  logic                   trap_i,
  input  hk_gpio_pkg::gpio_t     gpio_in_i,
  input  logic [11:0]            mfgr_id_i,
  input  logic [7:0]             prod_id_i,
  input  logic [3:0]             mask_rev_i,
  input  logic                   clk_ext_sel_i,
  output hk_gpio_pkg::gpio_t     gpio_out_o,
  output hk_gpio_pkg::gpio_t     gpio_outenb_o,
  output hk_gpio_pkg::gpio_t     gpio_pullupb_o,
  output hk_gpio_pkg::gpio_t     gpio_pulldownb_o,
  output logic                   irq7_o,
  output logic                   irq8_o
);

  logic                      pad_wr;
  hk_gpio_pkg::pad_bank_e    pad_bank;
  logic                      route_wr;
  hk_gpio_pkg::route_field_e route_field;
  hk_gpio_pkg::gpio_t        gpio_reg;
  hk_gpio_pkg::gpio_t        oeb_reg;
  hk_gpio_pkg::gpio_t        pu_reg;
  hk_gpio_pkg::gpio_t        pd_reg;
  hk_gpio_pkg::route_sel_t   xtal_dest;
  hk_gpio_pkg::route_sel_t   pll_dest;
  hk_gpio_pkg::route_sel_t   trap_dest;
  hk_gpio_pkg::route_sel_t   irq7_src;
  hk_gpio_pkg::route_sel_t   irq8_src;

  hk_bus_slave i_hk_bus_slave (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_valid_i   (bus_valid_i),
    .bus_addr_i    (bus_addr_i),
    .bus_wstrb_i   (bus_wstrb_i),
    .bus_ready_o   (bus_ready_o),
    .bus_rdata_o   (bus_rdata_o),
    .pad_wr_o      (pad_wr),
    .pad_bank_o    (pad_bank),
    .route_wr_o    (route_wr),
    .route_field_o (route_field),
    .gpio_out_i    (gpio_out_o),
    .gpio_in_i     (gpio_in_i),
    .oeb_i         (oeb_reg),
    .pu_i          (pu_reg),
    .pd_i          (pd_reg),
    .xtal_dest_i   (xtal_dest),
    .pll_dest_i    (pll_dest),
    .trap_dest_i   (trap_dest),
    .irq7_src_i    (irq7_src),
    .irq8_src_i    (irq8_src),
    .mfgr_id_i     (mfgr_id_i),
    .prod_id_i     (prod_id_i),
    .mask_rev_i    (mask_rev_i),
    .clk_ext_sel_i (clk_ext_sel_i)
  );

  gpio_pad_regs i_gpio_pad_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pad_wr_i   (pad_wr),
    .pad_bank_i (pad_bank),
    .wdata_i    (bus_wdata_i),
    .wstrb_i    (bus_wstrb_i),
    .gpio_o     (gpio_reg),
    .oeb_o      (oeb_reg),
    .pu_o       (pu_reg),
    .pd_o       (pd_reg)
  );

  pin_route_regs i_pin_route_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .route_wr_i    (route_wr),
    .route_field_i (route_field),
    .wdata_i       (bus_wdata_i),
    .wstrb_i       (bus_wstrb_i),
    .gpio_in_i     (gpio_in_i),
    .xtal_dest_o   (xtal_dest),
    .pll_dest_o    (pll_dest),
    .trap_dest_o   (trap_dest),
    .irq7_src_o    (irq7_src),
    .irq8_src_o    (irq8_src),
    .irq7_o        (irq7_o),
    .irq8_o        (irq8_o)
  );

  gpio_pad_mux i_gpio_pad_mux (
    .rst_n_i          (rst_n_i),
    .xtal_in_i        (xtal_in_i),
    .clk_pll_i        (clk_pll_i),
    .clk_i            (clk_i),
    .trap_i           (trap_i),
    .gpio_i           (gpio_reg),
    .oeb_i            (oeb_reg),
    .pu_i             (pu_reg),
    .pd_i             (pd_reg),
    .xtal_dest_i      (xtal_dest),
    .pll_dest_i       (pll_dest),
    .trap_dest_i      (trap_dest),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o)
  );

endmodule

// ==== include/tb_hk_gpio_model.svh ====
/* reference model of the GPIO block, LFSR stimulus source and typed compare tasks
   included inside tb_hk_gpio, it reads the testbench's DUT input signals directly */

  // fibonacci lfsr, taps 32 22 2 1
  logic [31:0] lfsr = 32'hd3805b73;

  // register mirror with reset values
  hk_gpio_pkg::gpio_t      m_gpio = '0;
  hk_gpio_pkg::gpio_t      m_oeb  = 16'hffff;
  hk_gpio_pkg::gpio_t      m_pu   = '0;
  hk_gpio_pkg::gpio_t      m_pd   = '0;
  hk_gpio_pkg::route_sel_t m_xtal = '0;
  hk_gpio_pkg::route_sel_t m_pll  = '0;
  hk_gpio_pkg::route_sel_t m_trap = '0;
  hk_gpio_pkg::route_sel_t m_irq7 = '0;
  hk_gpio_pkg::route_sel_t m_irq8 = '0;

  function automatic logic take_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic hk_gpio_pkg::bus_word_t take_bits(input int n);
    hk_gpio_pkg::bus_word_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  function automatic hk_gpio_pkg::gpio_t byte_lanes(input hk_gpio_pkg::gpio_t cur,
                                                    input hk_gpio_pkg::bus_word_t d,
                                                    input hk_gpio_pkg::bus_strb_t s);
    hk_gpio_pkg::gpio_t v;
    v = cur;
    if (s[0]) v[7:0] = d[7:0];
    if (s[1]) v[15:8] = d[15:8];
    return v;
  endfunction

  // pin values as seen on the pads
  function automatic hk_gpio_pkg::gpio_t exp_out();
    hk_gpio_pkg::gpio_t v;
    v = m_gpio;
    if (m_xtal != 2'd0) v[4 + m_xtal] = xtal_in_i;
    if (m_pll == 2'd1) v[8] = clk_pll_i;
    if (m_trap != 2'd0) v[10 + m_trap] = trap_i;
    return v;
  endfunction

  // pins taken over by an active route
  function automatic hk_gpio_pkg::gpio_t exp_grp();
    hk_gpio_pkg::gpio_t g;
    g = '0;
    if (m_xtal != 2'd0) g[7:5] = 3'b111;
    if (m_pll != 2'd0) g[10:8] = 3'b111;
    if (m_trap != 2'd0) g[13:11] = 3'b111;
    return g;
  endfunction

  function automatic logic exp_irq(input hk_gpio_pkg::route_sel_t sel, input int base);
    return (sel == 2'd0) ? 1'b0 : gpio_in_i[base + sel - 1];
  endfunction

  function automatic hk_gpio_pkg::bus_word_t model_read(input hk_gpio_pkg::bus_addr_t a);
    hk_gpio_pkg::bus_word_t v;
    v = '0;
    if (a[31:8] == hk_gpio_pkg::gpio_page) begin
      case (a[7:0])
        hk_gpio_pkg::ofs_data:     v = {exp_out(), gpio_in_i};
        hk_gpio_pkg::ofs_oeb:      v[15:0] = m_oeb;
        hk_gpio_pkg::ofs_pu:       v[15:0] = m_pu;
        hk_gpio_pkg::ofs_pd:       v[15:0] = m_pd;
        hk_gpio_pkg::ofs_mfgr_id:  v[11:0] = mfgr_id_i;
        hk_gpio_pkg::ofs_prod_id:  v[7:0] = prod_id_i;
        hk_gpio_pkg::ofs_mask_rev: v[3:0] = mask_rev_i;
        hk_gpio_pkg::ofs_clk_ext:  v[0] = clk_ext_sel_i;
        hk_gpio_pkg::ofs_xtal:     v[1:0] = m_xtal;
        hk_gpio_pkg::ofs_pll:      v[1:0] = m_pll;
        hk_gpio_pkg::ofs_trap:     v[1:0] = m_trap;
        hk_gpio_pkg::ofs_irq7:     v[1:0] = m_irq7;
        hk_gpio_pkg::ofs_irq8:     v[1:0] = m_irq8;
        default: ;
      endcase
    end
    return v;
  endfunction

  function automatic void model_write(input hk_gpio_pkg::bus_addr_t a,
                                      input hk_gpio_pkg::bus_word_t d,
                                      input hk_gpio_pkg::bus_strb_t s);
    if (a[31:8] != hk_gpio_pkg::gpio_page || s == '0) return;
    case (a[7:0])
      hk_gpio_pkg::ofs_data: m_gpio = byte_lanes(m_gpio, d, s);
      hk_gpio_pkg::ofs_oeb:  m_oeb = byte_lanes(m_oeb, d, s);
      hk_gpio_pkg::ofs_pu:   m_pu = byte_lanes(m_pu, d, s);
      hk_gpio_pkg::ofs_pd:   m_pd = byte_lanes(m_pd, d, s);
      hk_gpio_pkg::ofs_xtal: if (s[0]) m_xtal = d[1:0];
      hk_gpio_pkg::ofs_pll:  if (s[0]) m_pll = d[1:0];
      hk_gpio_pkg::ofs_trap: if (s[0]) m_trap = d[1:0];
      hk_gpio_pkg::ofs_irq7: if (s[0]) m_irq7 = d[1:0];
      hk_gpio_pkg::ofs_irq8: if (s[0]) m_irq8 = d[1:0];
      default: ;
    endcase
  endfunction

  // data readback holds pin 9, which follows clk_i while pll select is 2
  function automatic logic readback_ok(input hk_gpio_pkg::bus_addr_t a);
    return !(a == {hk_gpio_pkg::gpio_page, hk_gpio_pkg::ofs_data} && m_pll == 2'd2);
  endfunction

  task automatic check_word(input string name, input hk_gpio_pkg::bus_word_t got,
                            input hk_gpio_pkg::bus_word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pins(input string name, input hk_gpio_pkg::gpio_t got,
                            input hk_gpio_pkg::gpio_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

// ==== tests/tb_hk_gpio.sv ====
/* random bus traffic and pin stimulus against a behavioural model of the GPIO block
   the data register is not read back while pin 9 carries the core clock */
`timescale 1ns/1ps

module tb_hk_gpio;

  localparam int n_rand     = 300;
  localparam int n_stray    = 40;
  // three sweeps of all 13 offsets
  localparam int n_txn      = n_rand + n_stray + 3 * 13;
  localparam int clk_period = 20;
  localparam int wd_cycles  = 2 * n_txn * 4 + 3;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   bus_valid_i;
  hk_gpio_pkg::bus_addr_t bus_addr_i;
  hk_gpio_pkg::bus_word_t bus_wdata_i;
  hk_gpio_pkg::bus_strb_t bus_wstrb_i;
  logic                   bus_ready_o;
  hk_gpio_pkg::bus_word_t bus_rdata_o;
  logic                   xtal_in_i;
  logic                   clk_pll_i;
  logic                   trap_i;
  hk_gpio_pkg::gpio_t     gpio_in_i;
  logic [11:0]            mfgr_id_i;
  logic [7:0]             prod_id_i;
  logic [3:0]             mask_rev_i;
  logic                   clk_ext_sel_i;
  hk_gpio_pkg::gpio_t     gpio_out_o;
  hk_gpio_pkg::gpio_t     gpio_outenb_o;
  hk_gpio_pkg::gpio_t     gpio_pullupb_o;
  hk_gpio_pkg::gpio_t     gpio_pulldownb_o;
  logic                   irq7_o;
  logic                   irq8_o;

  // pad, routing, then ID offsets
  logic [7:0] reg_ofs [13] = '{8'h00, 8'h04, 8'h08, 8'h0c, 8'h34, 8'h38, 8'h3c,
                               8'h40, 8'h44, 8'h24, 8'h28, 8'h2c, 8'h30};

  hk_gpio_top i_hk_gpio_top (.*);

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  `include "tb_hk_gpio_model.svh"

  task automatic bus_access(input hk_gpio_pkg::bus_addr_t addr,
                            input hk_gpio_pkg::bus_word_t wdata,
                            input hk_gpio_pkg::bus_strb_t wstrb,
                            output hk_gpio_pkg::bus_word_t rdata);
    int waited;
    @(posedge clk_i);
    bus_valid_i <= 1'b1;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    bus_wstrb_i <= wstrb;
    waited = 0;
    do begin
      @(posedge clk_i);
      @(negedge clk_i);
      waited++;
    end while (!bus_ready_o && waited < 4);
    if (!bus_ready_o) begin
      $display("bus ready never arrived for address %h", addr);
      abort_run();
    end
    if (waited != 1) begin
      $display("bus ready arrived after %0d cycles instead of one", waited);
      abort_run();
    end
    rdata = bus_rdata_o;
    @(posedge clk_i);
    bus_valid_i <= 1'b0;
    bus_wstrb_i <= '0;
  endtask

  // random read or byte-strobed write with the read data checked against the model
  task automatic random_access(input hk_gpio_pkg::bus_addr_t addr);
    hk_gpio_pkg::bus_strb_t wstrb;
    hk_gpio_pkg::bus_word_t wdata;
    hk_gpio_pkg::bus_word_t exp;
    hk_gpio_pkg::bus_word_t got;
    wstrb = '0;
    if (take_bit()) wstrb = hk_gpio_pkg::bus_strb_t'(take_bits(4));
    wdata = take_bits(32);
    exp   = model_read(addr);
    bus_access(addr, wdata, wstrb, got);
    if (wstrb == '0 && readback_ok(addr)) check_word("bus_rdata_o", got, exp);
    model_write(addr, wdata, wstrb);
  endtask

  task automatic read_all();
    hk_gpio_pkg::bus_addr_t addr;
    hk_gpio_pkg::bus_word_t got;
    for (int i = 0; i < 13; i++) begin
      addr = {hk_gpio_pkg::gpio_page, reg_ofs[i]};
      bus_access(addr, '0, '0, got);
      if (readback_ok(addr)) check_word("bus_rdata_o", got, model_read(addr));
    end
  endtask

  task automatic drive_pads();
    @(posedge clk_i);
    xtal_in_i <= take_bit();
    clk_pll_i <= take_bit();
    trap_i    <= take_bit();
    gpio_in_i <= hk_gpio_pkg::gpio_t'(take_bits(16));
  endtask

  task automatic check_outputs();
    hk_gpio_pkg::gpio_t care;
    hk_gpio_pkg::gpio_t grp;
    @(negedge clk_i);
    care = '1;
    // only the enable and pulls of the core clock pin are predictable
    if (m_pll == 2'd2) care[9] = 1'b0;
    grp = exp_grp();
    check_pins("gpio_out_o", gpio_out_o & care, exp_out() & care);
    check_pins("gpio_outenb_o", gpio_outenb_o, m_oeb & ~grp);
    check_pins("gpio_pullupb_o", gpio_pullupb_o, m_pu | grp);
    check_pins("gpio_pulldownb_o", gpio_pulldownb_o, m_pd | grp);
    check_bit("irq7_o", irq7_o, exp_irq(m_irq7, 0));
    check_bit("irq8_o", irq8_o, exp_irq(m_irq8, 3));
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    abort_run();
  end

  initial begin
    hk_gpio_pkg::bus_addr_t addr;
    rst_n_i       = 1'b0;
    bus_valid_i   = 1'b0;
    bus_addr_i    = '0;
    bus_wdata_i   = '0;
    bus_wstrb_i   = '0;
    xtal_in_i     = 1'b0;
    clk_pll_i     = 1'b0;
    trap_i        = 1'b0;
    gpio_in_i     = '0;
    mfgr_id_i     = 12'(take_bits(12));
    prod_id_i     = 8'(take_bits(8));
    mask_rev_i    = 4'(take_bits(4));
    clk_ext_sel_i = take_bit();
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // reset values on the pins and in every register
    check_outputs();
    read_all();

    // pad and routing registers with toggling pad inputs
    for (int n = 0; n < n_rand; n++) begin
      random_access({hk_gpio_pkg::gpio_page, reg_ofs[int'(take_bits(4) % 9)]});
      drive_pads();
      check_outputs();
    end
    read_all();

    // unmapped offsets and off-page addresses
    for (int n = 0; n < n_stray; n++) begin
      if (take_bit()) begin
        addr = {hk_gpio_pkg::gpio_page, 8'h00} | take_bits(8);
      end else begin
        addr = take_bits(32);
      end
      random_access(addr);
      check_outputs();
    end

    // clock select strap flipped so both of its values are read back
    @(posedge clk_i);
    clk_ext_sel_i <= ~clk_ext_sel_i;
    read_all();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
design/hk_gpio_pkg.sv
design/hk_bus_slave.sv
design/gpio_pad_regs.sv
design/pin_route_regs.sv
design/gpio_pad_mux.sv
design/hk_gpio_top.sv
tests/tb_hk_gpio.sv
